//--- build.f
+incdir+hdl
+incdir+dv
hdl/shell_bus_pkg.sv
hdl/shell_sec_pkg.sv
hdl/scramble_key_ctrl.sv
hdl/register_file.sv
hdl/dside_tracker.sv
hdl/core_status.sv
hdl/core_shell_top.sv
dv/tb_core_shell.sv

//--- dv/tb_model.svh
//////////////////////////////////////////////////////////////////////
// Core shell reference models
// Expected register, key, tracker and status state per clock edge
//////////////////////////////////////////////////////////////////////

shell_bus_pkg::xlen_t      rf_m [`SHELL_RF_NUM_REGS];
shell_sec_pkg::scr_key_t   key_m;
shell_sec_pkg::scr_nonce_t nonce_m;
logic                      kvalid_m, req_m, err_m, busy_m;
int                        pend_m;

task automatic reset_models();
  foreach (rf_m[i]) begin
    rf_m[i] = '0;
  end
  key_m    = `SHELL_KEY_RESET;
  nonce_m  = `SHELL_NONCE_RESET;
  kvalid_m = 1'b1;
  req_m    = 1'b0;
  err_m    = 1'b0;
  busy_m   = 1'b0;
  pend_m   = 0;
endtask

// One rising edge, inputs are stable since the falling edge
task automatic step_models();
  if (rf_write_i.we && rf_write_i.waddr != '0) begin
    rf_m[rf_write_i.waddr] = rf_write_i.wdata;
  end
  if (scr_key_valid_i) begin
    key_m   = scr_key_i;
    nonce_m = scr_nonce_i;
  end
  // Pending request waits for the provider
  if (req_m) begin
    kvalid_m = scr_key_valid_i;
    req_m    = ~scr_key_valid_i;
  end else if (ic_scr_key_req_i) begin
    kvalid_m = 1'b0;
    req_m    = 1'b1;
  end
  // Stray response, or request into a full tracker
  err_m = (dside_bus_i.rvalid && pend_m == 0) ||
          (dside_bus_i.req && !dside_bus_i.rvalid && pend_m == `SHELL_MAX_DSIDE);
  if (dside_bus_i.rvalid && pend_m > 0) begin
    pend_m--;
  end
  if (dside_bus_i.req && dside_bus_i.gnt && pend_m < `SHELL_MAX_DSIDE) begin
    pend_m++;
  end
  busy_m = core_busy_i;
endtask

function automatic shell_sec_pkg::alerts_t alerts_expected();
  shell_sec_pkg::alerts_t a;
  a           = core_alerts_i;
  a.major_bus = a.major_bus | err_m;
  return a;
endfunction

//--- dv/tb_core_shell.sv
//////////////////////////////////////////////////////////////////////
// Core shell testbench
// Random stimulus on all shell ports, checked against reference models
//////////////////////////////////////////////////////////////////////

`include "shell_consts.svh"

module tb_core_shell;

  logic                      clk_i, rst_ni, core_busy_i, core_sleep_o;
  logic                      ic_scr_key_req_i, scr_key_valid_i, scr_req_o, scr_key_valid_o;
  shell_sec_pkg::scr_key_t   scr_key_i, scr_key_o;
  shell_sec_pkg::scr_nonce_t scr_nonce_i, scr_nonce_o;
  shell_bus_pkg::rf_addr_t   raddr_a_i, raddr_b_i;
  shell_bus_pkg::rf_write_t  rf_write_i;
  shell_bus_pkg::xlen_t      rdata_a_o, rdata_b_o;
  shell_bus_pkg::dside_bus_t dside_bus_i;
  shell_sec_pkg::wake_t      wake_i;
  shell_sec_pkg::alerts_t    core_alerts_i, alerts_o;
  logic [31:0]               lfsr_q = 32'h5cbb94f1;
  int                        errors, timeouts;
  string                     test_name;

  `include "tb_model.svh"

  core_shell_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      reset_models();
    end else begin
      step_models();
    end
  end

  // x^32 + x^22 + x^2 + x + 1, one step per bit taken
  function automatic logic [127:0] rand_bits(input int n);
    logic [127:0] r;
    logic         fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[126:0], fb};
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s %s: expected %0h, actual %0h", test_name, what, expected,
               actual);
    end
  endtask

  // Falling edge, compare all outputs before new inputs go out
  task automatic next_cycle();
    logic sleep_exp;
    @(negedge clk_i);
    sleep_exp = ~(busy_m | (|wake_i));
    check_value("rdata_a", 128'(rf_m[raddr_a_i]), 128'(rdata_a_o));
    check_value("rdata_b", 128'(rf_m[raddr_b_i]), 128'(rdata_b_o));
    check_value("scr_req", 128'(req_m), 128'(scr_req_o));
    check_value("scr_key_valid", 128'(kvalid_m), 128'(scr_key_valid_o));
    check_value("scr_key", key_m, scr_key_o);
    check_value("scr_nonce", 128'(nonce_m), 128'(scr_nonce_o));
    check_value("core_sleep", 128'(sleep_exp), 128'(core_sleep_o));
    check_value("alerts", 128'(alerts_expected()), 128'(alerts_o));
  endtask

  task automatic wait_key_req(input logic level);
    int n;
    n = 0;
    while (scr_req_o !== level && n < 20) begin
      next_cycle();
      n++;
    end
    if (scr_req_o !== level) begin
      timeouts++;
      $display("Timeout: key request did not go to %0b within 20 cycles", level);
    end
  endtask

  initial begin
    errors    = 0;
    timeouts  = 0;
    test_name = "reset";
    rst_ni    = 1'b0;
    {ic_scr_key_req_i, scr_key_valid_i, core_busy_i} = '0;
    {scr_key_i, scr_nonce_i, raddr_a_i, raddr_b_i} = '0;
    {rf_write_i, dside_bus_i, wake_i, core_alerts_i} = '0;
    repeat (16) @(negedge clk_i);
    rst_ni = 1'b1;
    next_cycle();

    //////////////////////////////////////////////////////////////////////
    // Register file, every eighth write aimed at x0
    test_name = "regfile";
    for (int i = 0; i < 200; i++) begin
      raddr_a_i        = 5'(rand_bits(5));
      raddr_b_i        = 5'(rand_bits(5));
      rf_write_i.we    = 1'(rand_bits(1));
      rf_write_i.waddr = (i % 8 == 0) ? '0 : 5'(rand_bits(5));
      rf_write_i.wdata = 32'(rand_bits(32));
      next_cycle();
    end
    rf_write_i = '{we: 1'b1, waddr: '0, wdata: 32'(rand_bits(32))};
    raddr_a_i  = '0;
    next_cycle();
    check_value("x0_zero", '0, 128'(rdata_a_o));
    rf_write_i.we = 1'b0;

    //////////////////////////////////////////////////////////////////////
    // Key handshake with a random provider delay
    test_name = "key_handshake";
    repeat (10) begin
      ic_scr_key_req_i = 1'b1;
      next_cycle();
      ic_scr_key_req_i = 1'b0;
      check_value("req_up", 128'(1'b1), 128'(scr_req_o));
      check_value("valid_down", 128'(1'b0), 128'(scr_key_valid_o));
      repeat (int'(rand_bits(3))) next_cycle();
      scr_key_i       = rand_bits(128);
      scr_nonce_i     = 64'(rand_bits(64));
      scr_key_valid_i = 1'b1;
      next_cycle();
      scr_key_valid_i = 1'b0;
      wait_key_req(1'b0);
      check_value("valid_up", 128'(1'b1), 128'(scr_key_valid_o));
      check_value("key", scr_key_i, scr_key_o);
      check_value("nonce", 128'(scr_nonce_i), 128'(scr_nonce_o));
    end

    //////////////////////////////////////////////////////////////////////
    // Legal data traffic, never past two pending
    test_name = "legal_traffic";
    repeat (300) begin
      dside_bus_i.rvalid = (pend_m > 0) && 1'(rand_bits(1));
      dside_bus_i.req    = (pend_m < `SHELL_MAX_DSIDE) && 1'(rand_bits(1));
      dside_bus_i.gnt    = 1'(rand_bits(1));
      core_alerts_i      = 3'(rand_bits(3));
      next_cycle();
      check_value("major_bus", 128'(core_alerts_i.major_bus), 128'(alerts_o.major_bus));
    end

    // Retire what is left, then break the protocol twice
    test_name     = "violations";
    core_alerts_i = '0;
    dside_bus_i   = '0;
    repeat (3) begin
      dside_bus_i.rvalid = pend_m > 0;
      next_cycle();
    end
    dside_bus_i = '{req: 1'b0, gnt: 1'b0, rvalid: 1'b1};
    next_cycle();
    dside_bus_i = '0;
    check_value("rsp_err_set", 128'(1'b1), 128'(alerts_o.major_bus));
    next_cycle();
    check_value("rsp_err_clear", 128'(1'b0), 128'(alerts_o.major_bus));
    // Two grants fill the tracker, the third request overflows
    dside_bus_i = '{req: 1'b1, gnt: 1'b1, rvalid: 1'b0};
    repeat (3) next_cycle();
    dside_bus_i = '0;
    check_value("req_err_set", 128'(1'b1), 128'(alerts_o.major_bus));
    next_cycle();
    check_value("req_err_clear", 128'(1'b0), 128'(alerts_o.major_bus));

    test_name = "sleep_alerts";
    repeat (200) begin
      core_busy_i   = 1'(rand_bits(1));
      wake_i        = 3'(rand_bits(3));
      core_alerts_i = 3'(rand_bits(3));
      next_cycle();
    end

    $display("Summary: %0d check failures, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- hdl/core_shell_top.sv
//////////////////////////////////////////////////////////////////////
// Core shell top
// Glue around the core: key handshake, regfile, tracker, status
//////////////////////////////////////////////////////////////////////

module core_shell_top (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  // Scrambling key
  input  logic                      ic_scr_key_req_i,
  input  logic                      scr_key_valid_i,
  input  shell_sec_pkg::scr_key_t   scr_key_i,
  input  shell_sec_pkg::scr_nonce_t scr_nonce_i,
  output logic                      scr_req_o,
  output logic                      scr_key_valid_o,
  output shell_sec_pkg::scr_key_t   scr_key_o,
  output shell_sec_pkg::scr_nonce_t scr_nonce_o,
  // Register file
  input  shell_bus_pkg::rf_addr_t   raddr_a_i,
  input  shell_bus_pkg::rf_addr_t   raddr_b_i,
  input  shell_bus_pkg::rf_write_t  rf_write_i,
  output shell_bus_pkg::xlen_t      rdata_a_o,
  output shell_bus_pkg::xlen_t      rdata_b_o,
  // Data bus, status and alerts
  input  shell_bus_pkg::dside_bus_t dside_bus_i,
  input  logic                      core_busy_i,
  input  shell_sec_pkg::wake_t      wake_i,
  input  shell_sec_pkg::alerts_t    core_alerts_i,
  output logic                      core_sleep_o,
  output shell_sec_pkg::alerts_t    alerts_o
);

  logic bus_err;

  scramble_key_ctrl u_scramble_key_ctrl (
    .clk_i,
    .rst_ni,
    .ic_scr_key_req_i,
    .scr_key_valid_i,
    .scr_key_i,
    .scr_nonce_i,
    .scr_req_o,
    .scr_key_valid_o,
    .scr_key_o,
    .scr_nonce_o
  );

  register_file u_register_file (
    .clk_i,
    .rst_ni,
    .raddr_a_i,
    .raddr_b_i,
    .rf_write_i,
    .rdata_a_o,
    .rdata_b_o
  );

  dside_tracker u_dside_tracker (
    .clk_i,
    .rst_ni,
    .dside_bus_i,
    .bus_err_o (bus_err)
  );

  core_status u_core_status (
    .clk_i,
    .rst_ni,
    .core_busy_i,
    .wake_i,
    .core_alerts_i,
    .bus_err_i (bus_err),
    .core_sleep_o,
    .alerts_o
  );

endmodule

//--- hdl/core_status.sv
//////////////////////////////////////////////////////////////////////
// Core status
// Busy register, sleep indication and alert merging
//////////////////////////////////////////////////////////////////////

module core_status (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   core_busy_i,
  input  shell_sec_pkg::wake_t   wake_i,
  input  shell_sec_pkg::alerts_t core_alerts_i,
  input  logic                   bus_err_i,
  output logic                   core_sleep_o,
  output shell_sec_pkg::alerts_t alerts_o
);

  logic core_busy_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  // Any wake source keeps the core running even when it is idle
  assign core_sleep_o = ~(core_busy_q | wake_i.debug_req |
                          wake_i.irq_pending | wake_i.irq_nm);

  // Tracker errors count as bus alerts
  always_comb begin
    alerts_o           = core_alerts_i;
    alerts_o.major_bus = core_alerts_i.major_bus | bus_err_i;
  end

endmodule

//--- hdl/dside_tracker.sv
//////////////////////////////////////////////////////////////////////
// Data-side access tracker
// Counts outstanding data accesses and flags bus protocol violations
//////////////////////////////////////////////////////////////////////

`include "shell_consts.svh"

module dside_tracker (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  shell_bus_pkg::dside_bus_t dside_bus_i,
  output logic                      bus_err_o
);

  // Slot 0 is the oldest pending access
  logic [`SHELL_MAX_DSIDE-1:0] pend_q, pend_shifted, pend_d;
  logic                        req_granted;
  logic                        rsp_unexpected;
  logic                        req_overflow;
  logic                        bus_err_q;

  assign req_granted = dside_bus_i.req & dside_bus_i.gnt;

  // A response retires the oldest access
  assign pend_shifted = dside_bus_i.rvalid ? (pend_q >> 1) : pend_q;

  // Granted request takes the lowest free slot after the shift.
  // With all slots full it is dropped, so the queue saturates
  always_comb begin
    logic placed;
    placed = 1'b0;
    pend_d = pend_shifted;
    for (int unsigned i = 0; i < `SHELL_MAX_DSIDE; i++) begin
      if (req_granted && !placed && !pend_shifted[i]) begin
        pend_d[i] = 1'b1;
        placed    = 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Protocol checks
  ////////////////////////////////////////////////////////////////////

  // Response with nothing outstanding
  assign rsp_unexpected = dside_bus_i.rvalid & ~pend_q[0];

  // New request while full, unless a slot frees up this cycle
  assign req_overflow = dside_bus_i.req & pend_q[`SHELL_MAX_DSIDE-1] &
                        ~dside_bus_i.rvalid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pend_q    <= '0;
      bus_err_q <= 1'b0;
    end else begin
      pend_q    <= pend_d;
      bus_err_q <= rsp_unexpected | req_overflow;
    end
  end

  assign bus_err_o = bus_err_q;

endmodule

//--- hdl/register_file.sv
//////////////////////////////////////////////////////////////////////
// Register file
// Flip-flop storage, two read ports, one write port, x0 tied to zero
//////////////////////////////////////////////////////////////////////

`include "shell_consts.svh"

module register_file (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  shell_bus_pkg::rf_addr_t  raddr_a_i,
  input  shell_bus_pkg::rf_addr_t  raddr_b_i,
  input  shell_bus_pkg::rf_write_t rf_write_i,
  output shell_bus_pkg::xlen_t     rdata_a_o,
  output shell_bus_pkg::xlen_t     rdata_b_o
);

  // Full view for the read muxes with x0 as the constant zero
  shell_bus_pkg::xlen_t            rf_reg   [`SHELL_RF_NUM_REGS-1:0];
  shell_bus_pkg::xlen_t            rf_reg_q [`SHELL_RF_NUM_REGS-1:1];
  logic [`SHELL_RF_NUM_REGS-1:1]   we_dec;

  ////////////////////////////////////////////////////////////////////
  // Write address decode
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int unsigned i = 1; i < `SHELL_RF_NUM_REGS; i++) begin
      we_dec[i] = rf_write_i.we &&
                  (rf_write_i.waddr == shell_bus_pkg::rf_addr_t'(i));
    end
  end

  ////////////////////////////////////////////////////////////////////
  // Storage
  ////////////////////////////////////////////////////////////////////

  // No flop for x0, so writes to it simply have no target
  for (genvar i = 1; i < `SHELL_RF_NUM_REGS; i++) begin : gen_rf_flops
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        rf_reg_q[i] <= '0;
      end else if (we_dec[i]) begin
        rf_reg_q[i] <= rf_write_i.wdata;
      end
    end
  end

  assign rf_reg[0]                      = '0;
  assign rf_reg[`SHELL_RF_NUM_REGS-1:1] = rf_reg_q;

  ////////////////////////////////////////////////////////////////////
  // Read ports
  ////////////////////////////////////////////////////////////////////

  assign rdata_a_o = rf_reg[raddr_a_i];
  assign rdata_b_o = rf_reg[raddr_b_i];

endmodule

//--- hdl/scramble_key_ctrl.sv
//////////////////////////////////////////////////////////////////////
// Scrambling key control
// Requests a fresh key on cache invalidate and holds key and nonce
//////////////////////////////////////////////////////////////////////

`include "shell_consts.svh"

module scramble_key_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      ic_scr_key_req_i,
  input  logic                      scr_key_valid_i,
  input  shell_sec_pkg::scr_key_t   scr_key_i,
  input  shell_sec_pkg::scr_nonce_t scr_nonce_i,
  output logic                      scr_req_o,
  output logic                      scr_key_valid_o,
  output shell_sec_pkg::scr_key_t   scr_key_o,
  output shell_sec_pkg::scr_nonce_t scr_nonce_o
);

  shell_sec_pkg::scr_key_t   key_q;
  shell_sec_pkg::scr_nonce_t nonce_q;
  logic                      key_valid_d, key_valid_q;
  logic                      req_d, req_q;

  // Valid follows the provider while a request is pending,
  // and drops as soon as the cache asks for a new key
  assign key_valid_d = req_q            ? scr_key_valid_i :
                       ic_scr_key_req_i ? 1'b0            :
                                          key_valid_q;

  // Request holds until the first valid key is seen
  assign req_d = req_q ? ~scr_key_valid_i : ic_scr_key_req_i;

  // Key material, loaded whenever the provider presents a key
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= `SHELL_KEY_RESET;
      nonce_q <= `SHELL_NONCE_RESET;
    end else if (scr_key_valid_i) begin
      key_q   <= scr_key_i;
      nonce_q <= scr_nonce_i;
    end
  end

  // Handshake state, key counts as valid out of reset
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_valid_q <= 1'b1;
      req_q       <= 1'b0;
    end else begin
      key_valid_q <= key_valid_d;
      req_q       <= req_d;
    end
  end

  assign scr_req_o       = req_q;
  assign scr_key_valid_o = key_valid_q;
  assign scr_key_o       = key_q;
  assign scr_nonce_o     = nonce_q;

endmodule

//--- hdl/shell_bus_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shell bus types
// Data bus handshake and register file access types
//////////////////////////////////////////////////////////////////////

`include "shell_consts.svh"

package shell_bus_pkg;

  // Data word and register index
  typedef logic [`SHELL_XLEN-1:0]      xlen_t;
  typedef logic [`SHELL_RF_ADDR_W-1:0] rf_addr_t;

  // Register file write port
  typedef struct packed {
    logic     we;
    rf_addr_t waddr;
    xlen_t    wdata;
  } rf_write_t;

  // Data-side bus control, as seen between core and memory
  typedef struct packed {
    logic req;
    logic gnt;
    logic rvalid;
  } dside_bus_t;

endpackage

//--- hdl/shell_consts.svh
//////////////////////////////////////////////////////////////////////
// Core shell constants
// Widths, counts and reset values shared by the shell packages and RTL
//////////////////////////////////////////////////////////////////////

`ifndef SHELL_CONSTS_SVH
`define SHELL_CONSTS_SVH

// Datapath and register file
`define SHELL_XLEN        32
`define SHELL_RF_ADDR_W   5
`define SHELL_RF_NUM_REGS 32

// Scrambling key and nonce
`define SHELL_KEY_W       128
`define SHELL_NONCE_W     64
`define SHELL_KEY_RESET   128'h3a9f_52c1_e047_8bd6_1f25_c4a8_970e_6b3d
`define SHELL_NONCE_RESET 64'hd41c_86a7_0b5e_f293

// Outstanding data-side accesses, one load/store may split in two
`define SHELL_MAX_DSIDE   2

`endif

//--- hdl/shell_sec_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shell security types
// Scrambling key material, alert outputs and wake sources
//////////////////////////////////////////////////////////////////////

`include "shell_consts.svh"

package shell_sec_pkg;

  // Instruction cache scrambling key and nonce
  typedef logic [`SHELL_KEY_W-1:0]   scr_key_t;
  typedef logic [`SHELL_NONCE_W-1:0] scr_nonce_t;

  // Alert classes
  typedef struct packed {
    logic minor;
    logic major_internal;
    logic major_bus;
  } alerts_t;

  // Anything that must keep the core awake
  typedef struct packed {
    logic debug_req;
    logic irq_pending;
    logic irq_nm;
  } wake_t;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the core shell testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing -f build.f --top-module tb_core_shell -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_core_shell > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$LOG"; then
  exit 1
fi
exit 0
